/* common/soc_pkg.sv */
package soc_pkg;

    localparam int XLEN = 64;

    // RAM region, 32-bit words
    localparam logic [XLEN-1:0] RAM_BASE = 64'h8000_0000;
    localparam int RAM_WORDS = 2048;
    localparam int RAM_AW = 11;

    // timer locations
    localparam logic [XLEN-1:0] MTIME_ADDR = 64'h0200_BFF8;
    localparam logic [XLEN-1:0] MTIMECMP_ADDR = 64'h0200_4000;
    localparam logic [XLEN-1:0] MTIMECMP_RESET = 64'h8000_0000;

    // interrupt controller map, offsets relative to PLIC_BASE
    localparam logic [XLEN-1:0] PLIC_BASE = 64'h0C00_0000;
    localparam logic [21:0] PLIC_PENDING_OFS = 22'h00_1000;
    localparam logic [21:0] PLIC_ENABLE_OFS = 22'h00_2000;
    localparam logic [21:0] ENABLE_STRIDE = 22'h00_0080;
    localparam logic [21:0] PLIC_THRESHOLD_OFS = 22'h20_0000;
    localparam logic [21:0] PLIC_CLAIM_OFS = 22'h20_0004;
    localparam logic [21:0] CONTEXT_STRIDE = 22'h00_1000;

    localparam int PLIC_SOURCES = 6;
    localparam int PRIO_W = 3;
    localparam int UART_IRQ_ID = 1;

    // access size field
    localparam logic [1:0] SZ_B = 2'b00;
    localparam logic [1:0] SZ_H = 2'b01;
    localparam logic [1:0] SZ_W = 2'b10;
    localparam logic [1:0] SZ_D = 2'b11;

    // load/store type from the core
    // loads  000 lb, 001 lh, 010 lw, 011 ld, 100 lbu, 101 lhu, 110 lwu
    // stores 000 sb, 001 sh, 010 sw, 011 sd
    typedef union packed {
        logic [2:0] code;
        struct packed {
            logic       is_unsigned;
            logic [1:0] size;
        } f;
    } ls_type_u;

endpackage

/* src/bus_fabric.sv */
`timescale 1ns/100ps

module bus_fabric import soc_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic [XLEN-1:0]   bus_address,
    input  logic [XLEN-1:0]   bus_write_data,
    input  logic [XLEN-1:0]   mtime,
    input  ls_type_u          bus_ls_type,
    input  logic              bus_read_enable,
    input  logic              bus_write_enable,
    output logic [XLEN-1:0]   bus_read_data,
    output logic              bus_read_done,
    output logic              bus_write_done,
    output logic              ram_sel,
    output logic [RAM_AW-1:0] ram_word,
    input  logic [XLEN-1:0]   ram_rdata,
    input  logic              ram_last,
    output logic              plic_sel,
    output logic [21:0]       plic_offset,
    output logic              plic_rd,
    output logic              plic_wr,
    input  logic [31:0]       plic_rdata
);

    logic            ram_hit;
    logic            plic_hit;
    logic            mtime_hit;
    logic            cmp_hit;
    logic            finish;
    logic [XLEN-1:0] mtimecmp;
    logic [XLEN-1:0] rd_mux;

    // address decode, address is held for the whole access
    assign ram_hit   = (bus_address >= RAM_BASE) &&
                       (bus_address < RAM_BASE + XLEN'(RAM_WORDS * 4));
    assign plic_hit  = bus_address[XLEN-1:22] == PLIC_BASE[XLEN-1:22];
    assign mtime_hit = bus_address == MTIME_ADDR;
    assign cmp_hit   = bus_address == MTIMECMP_ADDR;

    assign ram_sel     = ram_hit;
    assign plic_sel    = plic_hit;
    assign plic_offset = bus_address[21:0];
    assign plic_rd     = !bus_read_done;  // qualified by plic_sel downstream
    assign plic_wr     = !bus_write_done;

    // doubleword RAM accesses stretch until the port reports its last step
    assign finish = !ram_hit || ram_last;

    // word index latched with the enable
    always_ff @(posedge CLOCK_50) begin
        if (bus_read_enable || bus_write_enable) begin
            ram_word <= bus_address[RAM_AW+1:2];
        end
    end

    always_comb begin
        rd_mux = '0; // unmapped reads return zero
        if (ram_hit) begin
            rd_mux = ram_rdata; // already extended by the RAM port
        end else if (plic_hit) begin
            rd_mux = XLEN'(plic_rdata);
        end else if (mtime_hit) begin
            rd_mux = mtime;
        end else if (cmp_hit) begin
            rd_mux = mtimecmp;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data  <= '0;
            mtimecmp       <= MTIMECMP_RESET;
        end else begin
            if (bus_read_enable) begin
                bus_read_done <= 1'b0;
            end else if (!bus_read_done && finish) begin
                bus_read_data <= rd_mux;
                bus_read_done <= 1'b1;
            end

            if (bus_write_enable) begin
                bus_write_done <= 1'b0;
            end else if (!bus_write_done && finish) begin
                if (cmp_hit) begin
                    mtimecmp <= bus_write_data;
                end
                bus_write_done <= 1'b1; // unmapped writes just complete
            end
        end
    end

    a_one_enable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable))
        else $error("read and write enable high together");

    // only one access in flight
    a_no_overlap: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (bus_read_enable || bus_write_enable) |-> (bus_read_done && bus_write_done))
        else $error("new access started before the previous one completed");

    // the type only matters to the RAM port, but it must stay stable meanwhile
    a_type_stable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (!bus_read_done || !bus_write_done) |-> $stable(bus_ls_type.code))
        else $error("load/store type changed during an access");

endmodule

/* ram/ram_port.sv */
`timescale 1ns/100ps

module ram_port import soc_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              ram_sel,
    input  logic [RAM_AW-1:0] ram_word,
    input  logic [1:0]        bus_address,
    input  logic [XLEN-1:0]   bus_write_data,
    input  ls_type_u          bus_ls_type,
    input  logic              bus_read_done,
    input  logic              bus_write_done,
    output logic [XLEN-1:0]   ram_rdata,
    output logic              ram_last
);

    logic [31:0]       mem [RAM_WORDS];
    logic              step;      // upper word of ld/sd
    logic [31:0]       low_hold;  // lower word of ld
    logic [RAM_AW-1:0] idx;
    logic [31:0]       word;
    logic [31:0]       shifted;
    logic              sx;
    logic              rd_act;
    logic              wr_act;
    logic [3:0]        wmask;
    logic [31:0]       wdata;

    assign rd_act = ram_sel && !bus_read_done;
    assign wr_act = ram_sel && !bus_write_done;

    assign idx  = ram_word + RAM_AW'(step);
    assign word = mem[idx];

    assign ram_last = (bus_ls_type.f.size != SZ_D) || step;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            step <= 1'b0;
        end else if ((rd_act || wr_act) && bus_ls_type.f.size == SZ_D) begin
            step <= !step;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (rd_act && !step) begin
            low_hold <= word;
        end
    end

    // load path, shift down to lane 0 then extend
    always_comb begin
        shifted = word >> {bus_address, 3'b000};
        sx      = !bus_ls_type.f.is_unsigned;
        case (bus_ls_type.f.size)
            SZ_B:    ram_rdata = {{(XLEN-8){sx & shifted[7]}}, shifted[7:0]};
            SZ_H:    ram_rdata = {{(XLEN-16){sx & shifted[15]}}, shifted[15:0]};
            SZ_W:    ram_rdata = {{(XLEN-32){sx & shifted[31]}}, shifted};
            default: ram_rdata = {word, low_hold}; // ld, upper word on step 1
        endcase
    end

    // store lanes from the byte offset
    always_comb begin
        wmask = 4'b0000;
        wdata = bus_write_data[31:0];
        case (bus_ls_type.code)
            3'b000: begin // sb
                wmask = 4'b0001 << bus_address;
                wdata = {4{bus_write_data[7:0]}};
            end
            3'b001: begin // sh
                wmask = 4'b0011 << bus_address;
                wdata = {2{bus_write_data[15:0]}};
            end
            3'b010: begin // sw
                wmask = 4'b1111;
            end
            3'b011: begin // sd, one word per step
                wmask = 4'b1111;
                wdata = step ? bus_write_data[63:32] : bus_write_data[31:0];
            end
            default: begin
                wmask = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (wr_act) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    a_half_aligned: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ((rd_act || wr_act) && bus_ls_type.f.size == SZ_H) |-> !bus_address[0])
        else $error("misaligned half-word access");

endmodule

/* plic/plic.sv */
`timescale 1ns/100ps

module plic import soc_pkg::*; (
    input  logic            CLOCK_50,
    input  logic            KEY0,
    input  logic            plic_sel,
    input  logic            plic_rd,
    input  logic            plic_wr,
    input  logic [21:0]     plic_offset,
    input  logic [XLEN-1:0] bus_write_data,
    input  logic            uart_irq,
    output logic [31:0]     plic_rdata,
    output logic            meip_interrupt,
    output logic            msip_interrupt
);

    logic [PRIO_W-1:0]       prio [PLIC_SOURCES];
    logic [PLIC_SOURCES-1:0] pending;
    logic [PLIC_SOURCES-1:0] enable [2];    // context 0 M, context 1 S
    logic [PRIO_W-1:0]       threshold [2];
    logic [31:0]             claim [2];
    logic                    uart_irq_q;
    logic                    rd_stb;
    logic                    wr_stb;
    logic                    prio_hit;
    logic                    pend_hit;
    logic [2:0]              prio_idx;
    logic [1:0]              en_hit;
    logic [1:0]              th_hit;
    logic [1:0]              cl_hit;

    assign rd_stb = plic_sel && plic_rd;
    assign wr_stb = plic_sel && plic_wr;

    // priority slots sit at 4 bytes per source id
    assign prio_idx = plic_offset[4:2];
    assign prio_hit = (plic_offset[21:12] == '0) && (plic_offset[11:2] < 10'(PLIC_SOURCES));
    assign pend_hit = plic_offset == PLIC_PENDING_OFS;

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            en_hit[c] = plic_offset == PLIC_ENABLE_OFS + 22'(c) * ENABLE_STRIDE;
            th_hit[c] = plic_offset == PLIC_THRESHOLD_OFS + 22'(c) * CONTEXT_STRIDE;
            cl_hit[c] = plic_offset == PLIC_CLAIM_OFS + 22'(c) * CONTEXT_STRIDE;
            // uart is the only wired source
            claim[c] = (pending[UART_IRQ_ID] && enable[c][UART_IRQ_ID]) ?
                       32'(UART_IRQ_ID) : 32'd0;
        end
    end

    assign meip_interrupt = claim[0] != 32'd0;
    assign msip_interrupt = claim[1] != 32'd0;

    always_comb begin
        plic_rdata = '0;
        if (prio_hit) begin
            plic_rdata = 32'(prio[prio_idx]);
        end else if (pend_hit) begin
            plic_rdata = 32'(pending);
        end
        for (int c = 0; c < 2; c++) begin
            if (en_hit[c]) begin
                plic_rdata = 32'(enable[c]);
            end
            if (th_hit[c]) begin
                plic_rdata = 32'(threshold[c]);
            end
            if (cl_hit[c]) begin
                plic_rdata = claim[c];
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_irq_q <= 1'b0;
            pending    <= '0;
            prio       <= '{default: '0};
            enable     <= '{default: '0};
            threshold  <= '{default: '0};
        end else begin
            uart_irq_q <= uart_irq;
            if (uart_irq && !uart_irq_q) begin
                pending[UART_IRQ_ID] <= 1'b1; // rising edge only
            end
            if (wr_stb && prio_hit) begin
                prio[prio_idx] <= bus_write_data[PRIO_W-1:0];
            end
            for (int c = 0; c < 2; c++) begin
                if (wr_stb && en_hit[c]) begin
                    enable[c] <= bus_write_data[PLIC_SOURCES-1:0];
                end
                if (wr_stb && th_hit[c]) begin
                    threshold[c] <= bus_write_data[PRIO_W-1:0];
                end
                // claim read wins over a new edge in the same cycle
                if (rd_stb && cl_hit[c] && claim[c] != 32'd0) begin
                    pending[UART_IRQ_ID] <= 1'b0;
                end
            end
        end
    end

    a_claim_range: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (claim[0] <= 32'(PLIC_SOURCES)) && (claim[1] <= 32'(PLIC_SOURCES)))
        else $error("claim id out of range");

endmodule

/* src/soc_bus_top.sv */
`timescale 1ns/100ps

module soc_bus_top import soc_pkg::*; (
    input  logic            CLOCK_50,
    input  logic            KEY0,
    input  logic [XLEN-1:0] bus_address,
    input  logic [XLEN-1:0] bus_write_data,
    input  logic [XLEN-1:0] mtime,
    input  ls_type_u        bus_ls_type,
    input  logic            bus_read_enable,
    input  logic            bus_write_enable,
    input  logic            uart_irq,
    output logic [XLEN-1:0] bus_read_data,
    output logic            bus_read_done,
    output logic            bus_write_done,
    output logic            meip_interrupt,
    output logic            msip_interrupt
);

    logic              ram_sel;
    logic [RAM_AW-1:0] ram_word;
    logic [XLEN-1:0]   ram_rdata;
    logic              ram_last;

    logic              plic_sel;
    logic [21:0]       plic_offset;
    logic              plic_rd;
    logic              plic_wr;
    logic [31:0]       plic_rdata;

    bus_fabric i_bus_fabric (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .mtime            (mtime),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram_sel          (ram_sel),
        .ram_word         (ram_word),
        .ram_rdata        (ram_rdata),
        .ram_last         (ram_last),
        .plic_sel         (plic_sel),
        .plic_offset      (plic_offset),
        .plic_rd          (plic_rd),
        .plic_wr          (plic_wr),
        .plic_rdata       (plic_rdata)
    );

    ram_port i_ram_port (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .ram_sel        (ram_sel),
        .ram_word       (ram_word),
        .bus_address    (bus_address[1:0]), // byte offset only
        .bus_write_data (bus_write_data),
        .bus_ls_type    (bus_ls_type),
        .bus_read_done  (bus_read_done),
        .bus_write_done (bus_write_done),
        .ram_rdata      (ram_rdata),
        .ram_last       (ram_last)
    );

    plic i_plic (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .plic_sel       (plic_sel),
        .plic_rd        (plic_rd),
        .plic_wr        (plic_wr),
        .plic_offset    (plic_offset),
        .bus_write_data (bus_write_data),
        .uart_irq       (uart_irq),
        .plic_rdata     (plic_rdata),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

/* testbench/tb_soc_bus.sv */
`timescale 1ns/100ps

module tb_soc_bus import soc_pkg::*; ();

    logic            CLOCK_50;
    logic            KEY0;
    logic [XLEN-1:0] bus_address;
    logic [XLEN-1:0] bus_write_data;
    logic [XLEN-1:0] mtime;
    ls_type_u        bus_ls_type;
    logic            bus_read_enable;
    logic            bus_write_enable;
    logic            uart_irq;
    logic [XLEN-1:0] bus_read_data;
    logic            bus_read_done;
    logic            bus_write_done;
    logic            meip_interrupt;
    logic            msip_interrupt;

    int checks;
    int mismatches;
    int other_errors;

    soc_bus_top i_dut (.*);

    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = !CLOCK_50;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // done rises on the second edge or on the third for ld/sd in RAM
    function automatic int expected_edges(input logic [2:0] ty, input logic [63:0] addr);
        if (addr >= RAM_BASE && addr < RAM_BASE + 64'(RAM_WORDS * 4) && ty[1:0] == 2'b11) begin
            return 3;
        end
        return 2;
    endfunction

    // starts on a falling edge and returns on the falling edge after done rises
    task automatic bus_access(input logic wr, input logic [2:0] ty, input logic [63:0] addr,
                              input logic [63:0] wdata, output int edges);
        int n;
        bus_address      = addr;
        bus_write_data   = wdata;
        bus_ls_type.code = ty;
        bus_write_enable = wr;
        bus_read_enable  = !wr;
        @(negedge CLOCK_50); // enable sampled on edge 1
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        n = 1;
        while (!(wr ? bus_write_done : bus_read_done) && n < 20) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (!(wr ? bus_write_done : bus_read_done)) begin
            other_errors++;
            $display("timeout: access to address %h did not complete within 20 cycles", addr);
        end
        edges = n;
    endtask

    task automatic pulse_uart_irq();
        uart_irq = 1'b1;
        @(negedge CLOCK_50);
        uart_irq = 1'b0;
        @(negedge CLOCK_50);
    endtask

    initial begin
        int unsigned mtime_hi;
        int          fd;
        int          rc;
        int          edges;
        string       line;
        logic [7:0]  op;
        logic [63:0] f_type;
        logic [63:0] f_addr;
        logic [63:0] f_wdata;
        logic [63:0] f_exp;
        logic [63:0] f_meip;
        logic [63:0] f_msip;

        checks           = 0;
        mismatches       = 0;
        other_errors     = 0;
        mtime_hi         = $urandom(32'hccef97fc); // seeds the generator, upper half
        mtime            = {mtime_hi, $urandom()};
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type.code = 3'b000;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        uart_irq         = 1'b0;
        repeat (5) @(negedge CLOCK_50);
        KEY0 = 1'b1;
        @(negedge CLOCK_50);

        check_value("bus_read_done", 64'(bus_read_done), 64'd1);
        check_value("bus_write_done", 64'(bus_write_done), 64'd1);
        check_value("bus_read_data", bus_read_data, 64'd0);

        fd = $fopen("testbench/bus_trace.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the trace file testbench/bus_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc == 0 || line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                rc = $sscanf(line, "%s %h %h %h %h %h %h", op, f_type, f_addr, f_wdata,
                             f_exp, f_meip, f_msip);
                if (rc != 7) begin
                    other_errors++;
                    $display("trace line could not be parsed: %s", line);
                    continue;
                end
                case (op)
                    "R", "T": begin
                        bus_access(1'b0, f_type[2:0], f_addr, f_wdata, edges);
                        if (op == "T") begin
                            f_exp = mtime; // marker for the random mtime value
                        end
                        check_value("bus_read_data", bus_read_data, f_exp);
                        check_value("read done edge", 64'(edges),
                                    64'(expected_edges(f_type[2:0], f_addr)));
                    end
                    "W": begin
                        bus_access(1'b1, f_type[2:0], f_addr, f_wdata, edges);
                        check_value("write done edge", 64'(edges),
                                    64'(expected_edges(f_type[2:0], f_addr)));
                    end
                    "I": pulse_uart_irq();
                    default: begin
                        other_errors++;
                        $display("unknown operation in trace line: %s", line);
                    end
                endcase
                check_value("meip_interrupt", 64'(meip_interrupt), f_meip);
                check_value("msip_interrupt", 64'(msip_interrupt), f_msip);
            end
            $fclose(fd);
        end

        $display("checks %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* testbench/bus_trace.txt */
# op type address wdata expected_rdata meip msip
# op R read, W write, I uart_irq pulse, T read that expects the mtime input
W 2 80000000 0000000089abcdef 0 0 0
R 6 80000000 0 0000000089abcdef 0 0
R 2 80000000 0 ffffffff89abcdef 0 0
W 0 80000010 00000000aaaaaa12 0 0 0
W 0 80000011 0000000000000085 0 0 0
W 0 80000012 000000000000007f 0 0 0
W 0 80000013 00000000000000c0 0 0 0
R 0 80000011 0 ffffffffffffff85 0 0
R 4 80000011 0 0000000000000085 0 0
R 0 80000010 0 0000000000000012 0 0
R 4 80000013 0 00000000000000c0 0 0
R 2 80000010 0 ffffffffc07f8512 0 0
W 1 80000020 0000000000008001 0 0 0
W 1 80000022 00000000ffff1234 0 0 0
R 1 80000020 0 ffffffffffff8001 0 0
R 5 80000020 0 0000000000008001 0 0
R 1 80000022 0 0000000000001234 0 0
W 3 80000040 0123456789abcdef 0 0 0
R 3 80000040 0 0123456789abcdef 0 0
R 6 80000044 0 0000000001234567 0 0
R 3 02004000 0 0000000080000000 0 0
W 3 02004000 000000123456789a 0 0 0
R 3 02004000 0 000000123456789a 0 0
T 3 0200bff8 0 0 0 0
I 0 0 0 0 0 0
W 2 0c002000 0000000000000002 0 1 0
R 2 0c200004 0 0000000000000001 0 0
R 2 0c001000 0 0000000000000000 0 0
R 3 00001000 0 0000000000000000 0 0

/* files.f */
common/soc_pkg.sv
src/bus_fabric.sv
ram/ram_port.sv
plic/plic.sv
src/soc_bus_top.sv
testbench/tb_soc_bus.sv

/* run_sim.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert -f files.f --top-module tb_soc_bus -o tb_soc_bus

out=$(./obj_dir/tb_soc_bus)
echo "$out"

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
